// ==== tetris_macros.svh ====
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// playfield size
`define BOARD_WIDTH 10
`define BOARD_HEIGHT 20

// cell coordinate and score widths
`define ROW_BITS 5
`define COL_BITS 4
`define SCORE_BITS 16

// leftmost column of a freshly spawned piece
`define SPAWN_COL 5

// shape codes
`define SHAPE_SQUARE 2'd0
`define SHAPE_HBAR 2'd1
`define SHAPE_VBAR 2'd2
`define SHAPE_TEE 2'd3

// direction codes
`define DIR_LEFT 2'd0
`define DIR_RIGHT 2'd1
`define DIR_DOWN 2'd2

// command op, any other value means a move
`define CMD_SPAWN (1'b1)

// controller states
`define ST_SPAWN 3'd0
`define ST_CHECK_KEY 3'd1
`define ST_MOVE_LEFT 3'd2
`define ST_MOVE_RIGHT 3'd3
`define ST_CHECK_FALL 3'd4
`define ST_FALL 3'd5
`define ST_CLEAR 3'd6

`endif

// ==== tetrisPkg.sv ====
`default_nettype none

package tetrisPkg;

	// piece command argument
	// the same two bits are a shape code on a spawn and a
	// direction code on a move, cmdOp tells which
	typedef union packed {
		logic [1:0] spawnShape;
		logic [1:0] moveDir;
	} pieceCmdU;

endpackage

`default_nettype wire

// ==== boardIf.sv ====
`default_nettype none

`include "tetris_macros.svh"

interface boardIf import tetrisPkg::*; ();

	// board lookups for the candidate cells, one per piece cell
	logic [3:0][`ROW_BITS-1:0] probeRow;
	logic [3:0][`COL_BITS-1:0] probeCol;
	logic [3:0] probeHit;

	// command from the controller
	logic cmdOp;
	pieceCmdU cmdArg;

	// active piece cells and the redraw strobe
	logic [3:0][`ROW_BITS-1:0] oldRow;
	logic [3:0][`COL_BITS-1:0] oldCol;
	logic drawEn;

	// candidate cells and collision result
	logic [3:0][`ROW_BITS-1:0] newRow;
	logic [3:0][`COL_BITS-1:0] newCol;
	logic blocked;

	// row sweep
	logic clearStart;
	logic clearBusy;

	modport control (
		output cmdOp, cmdArg, oldRow, oldCol, drawEn, clearStart,
		input newRow, newCol, blocked, clearBusy
	);

	modport probeCmd (
		input cmdOp, cmdArg, oldRow, oldCol,
		output newRow, newCol, blocked
	);

	modport probe (
		output probeRow, probeCol,
		input probeHit
	);

	modport store (
		input probeRow, probeCol, cmdOp, oldRow, oldCol, newRow, newCol,
		input drawEn, clearStart,
		output probeHit, clearBusy
	);

endinterface

`default_nettype wire

// ==== pieceProbe.sv ====
`default_nettype none

`include "tetris_macros.svh"

module pieceProbe import tetrisPkg::*; (
	boardIf.probeCmd ctl,
	boardIf.probe brd
);

	pieceCmdU cmd;

	// spawn offsets from row 0 and SPAWN_COL
	logic [3:0][1:0] rowOff;
	logic [3:0][1:0] colOff;

	logic [3:0][`ROW_BITS-1:0] candRow;
	logic [3:0][`COL_BITS-1:0] candCol;
	logic [3:0] outside;
	logic [3:0] selfHit;
	logic isSpawn;

	assign cmd = ctl.cmdArg;
	assign isSpawn = (ctl.cmdOp == `CMD_SPAWN);

	// shape table, the leftmost entry of each list is cell 3
	always_comb begin
		case (cmd.spawnShape)
			`SHAPE_SQUARE: begin
				rowOff = {2'd1, 2'd1, 2'd0, 2'd0};
				colOff = {2'd1, 2'd0, 2'd1, 2'd0};
			end
			`SHAPE_HBAR: begin
				rowOff = {2'd0, 2'd0, 2'd0, 2'd0};
				colOff = {2'd3, 2'd2, 2'd1, 2'd0};
			end
			`SHAPE_VBAR: begin
				rowOff = {2'd3, 2'd2, 2'd1, 2'd0};
				colOff = {2'd0, 2'd0, 2'd0, 2'd0};
			end
			default: begin
				// tee, three across with a stem under the middle
				rowOff = {2'd1, 2'd0, 2'd0, 2'd0};
				colOff = {2'd1, 2'd2, 2'd1, 2'd0};
			end
		endcase
	end

	// candidate cells and the board edge check
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			candRow[i] = ctl.oldRow[i];
			candCol[i] = ctl.oldCol[i];
			outside[i] = 1'b0;
			if (isSpawn) begin
				candRow[i] = `ROW_BITS'(rowOff[i]);
				candCol[i] = `COL_BITS'(`SPAWN_COL) + `COL_BITS'(colOff[i]);
			end else begin
				case (cmd.moveDir)
					`DIR_LEFT: begin
						candCol[i] = ctl.oldCol[i] - `COL_BITS'(1);
						outside[i] = (ctl.oldCol[i] == '0);
					end
					`DIR_RIGHT: begin
						candCol[i] = ctl.oldCol[i] + `COL_BITS'(1);
						outside[i] = (ctl.oldCol[i] == `COL_BITS'(`BOARD_WIDTH - 1));
					end
					`DIR_DOWN: begin
						candRow[i] = ctl.oldRow[i] + `ROW_BITS'(1);
						outside[i] = (ctl.oldRow[i] == `ROW_BITS'(`BOARD_HEIGHT - 1));
					end
					default: outside[i] = 1'b1;
				endcase
			end
		end
	end

	// a set cell only counts when the piece itself is not sitting there
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			selfHit[i] = 1'b0;
			for (int j = 0; j < 4; j++) begin
				if (candRow[i] == ctl.oldRow[j] && candCol[i] == ctl.oldCol[j]) begin
					selfHit[i] = 1'b1;
				end
			end
		end
	end

	assign brd.probeRow = candRow;
	assign brd.probeCol = candCol;

	assign ctl.newRow = candRow;
	assign ctl.newCol = candCol;

	// spawns overwrite whatever is there
	assign ctl.blocked = !isSpawn && |(outside | (brd.probeHit & ~selfHit));

endmodule

`default_nettype wire

// ==== boardStore.sv ====
`default_nettype none

`include "tetris_macros.svh"

module boardStore (
	input logic count,
	input logic rst,
	boardIf.store brd,
	input logic [`ROW_BITS-1:0] rowSel,
	output logic [`BOARD_WIDTH-1:0] rowData
);

	// row 0 is the top, bit c of a row is column c
	logic [`BOARD_HEIGHT-1:0][`BOARD_WIDTH-1:0] board;

	logic [`ROW_BITS-1:0] scanRow;
	logic busy;
	logic rowFull;

	assign rowFull = &board[scanRow];
	assign brd.clearBusy = busy;

	// collision lookups, anything off the board reads as empty
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			if (brd.probeRow[i] < `ROW_BITS'(`BOARD_HEIGHT) &&
					brd.probeCol[i] < `COL_BITS'(`BOARD_WIDTH)) begin
				brd.probeHit[i] = board[brd.probeRow[i]][brd.probeCol[i]];
			end else begin
				brd.probeHit[i] = 1'b0;
			end
		end
	end

	// read port for the outside world
	always_comb begin
		if (rowSel < `ROW_BITS'(`BOARD_HEIGHT)) begin
			rowData = board[rowSel];
		end else begin
			rowData = '0;
		end
	end

	always_ff @(posedge count) begin
		if (rst) begin
			board <= '0;
			busy <= 1'b0;
			scanRow <= '0;
		end else if (brd.clearStart) begin
			// sweep begins at the bottom
			busy <= 1'b1;
			scanRow <= `ROW_BITS'(`BOARD_HEIGHT - 1);
		end else if (busy) begin
			if (rowFull) begin
				// drop everything above, then look at the same row again
				for (int r = 1; r < `BOARD_HEIGHT; r++) begin
					if (`ROW_BITS'(r) <= scanRow) begin
						board[r] <= board[r-1];
					end
				end
				board[0] <= '0;
			end else if (scanRow == '0) begin
				busy <= 1'b0;
			end else begin
				scanRow <= scanRow - `ROW_BITS'(1);
			end
		end else if (brd.drawEn) begin
			// erase first so the overlap with the new cells stays set
			if (brd.cmdOp != `CMD_SPAWN) begin
				for (int i = 0; i < 4; i++) begin
					board[brd.oldRow[i]][brd.oldCol[i]] <= 1'b0;
				end
			end
			for (int i = 0; i < 4; i++) begin
				board[brd.newRow[i]][brd.newCol[i]] <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== gameCtrl.sv ====
`default_nettype none

`include "tetris_macros.svh"

module gameCtrl import tetrisPkg::*; (
	input logic count,
	input logic rst,
	input logic left,
	input logic right,
	input logic [1:0] newShape,
	boardIf.control ctl,
	output logic [`SCORE_BITS-1:0] score,
	output logic lockPulse
);

	logic [2:0] state;
	logic [2:0] nextState;

	// active piece cells
	logic [3:0][`ROW_BITS-1:0] pieceRow;
	logic [3:0][`COL_BITS-1:0] pieceCol;

	pieceCmdU cmd;
	logic commit;
	logic lockNow;

	assign ctl.cmdArg = cmd;
	assign ctl.oldRow = pieceRow;
	assign ctl.oldCol = pieceCol;
	assign ctl.drawEn = commit;
	// the sweep starts in the same cycle the lock is reported
	assign ctl.clearStart = lockPulse;

	assign lockNow = (state == `ST_CHECK_FALL) && ctl.blocked;

	always_comb begin
		ctl.cmdOp = ~`CMD_SPAWN;
		cmd.moveDir = `DIR_DOWN;
		commit = 1'b0;
		nextState = state;
		case (state)
			`ST_SPAWN: begin
				ctl.cmdOp = `CMD_SPAWN;
				cmd.spawnShape = newShape;
				commit = !ctl.blocked;
				nextState = `ST_CHECK_KEY;
			end
			`ST_CHECK_KEY: begin
				// keys are active low, left wins when both are held
				nextState = `ST_CHECK_FALL;
				if (!left) begin
					cmd.moveDir = `DIR_LEFT;
					if (!ctl.blocked) begin
						nextState = `ST_MOVE_LEFT;
					end
				end else if (!right) begin
					cmd.moveDir = `DIR_RIGHT;
					if (!ctl.blocked) begin
						nextState = `ST_MOVE_RIGHT;
					end
				end
			end
			`ST_MOVE_LEFT: begin
				cmd.moveDir = `DIR_LEFT;
				commit = !ctl.blocked;
				nextState = `ST_CHECK_FALL;
			end
			`ST_MOVE_RIGHT: begin
				cmd.moveDir = `DIR_RIGHT;
				commit = !ctl.blocked;
				nextState = `ST_CHECK_FALL;
			end
			`ST_CHECK_FALL: begin
				nextState = ctl.blocked ? `ST_CLEAR : `ST_FALL;
			end
			`ST_FALL: begin
				commit = !ctl.blocked;
				nextState = `ST_CHECK_KEY;
			end
			`ST_CLEAR: begin
				// wait for the sweep to start and then finish
				if (!lockPulse && !ctl.clearBusy) begin
					nextState = `ST_SPAWN;
				end
			end
			default: nextState = `ST_SPAWN;
		endcase
	end

	always_ff @(posedge count) begin
		if (rst) begin
			state <= `ST_SPAWN;
			score <= '0;
			lockPulse <= 1'b0;
		end else begin
			state <= nextState;
			lockPulse <= lockNow;
			if (lockNow) begin
				score <= score + `SCORE_BITS'(1);
			end
		end
	end

	// take over the probe's cells whenever the board is redrawn
	always_ff @(posedge count) begin
		if (commit) begin
			pieceRow <= ctl.newRow;
			pieceCol <= ctl.newCol;
		end
	end

endmodule

`default_nettype wire

// ==== tetrisCore.sv ====
`default_nettype none

`include "tetris_macros.svh"

module tetrisCore (
	input logic count,
	input logic rst,
	input logic left,
	input logic right,
	input logic [1:0] newShape,
	input logic [`ROW_BITS-1:0] rowSel,
	output logic [`BOARD_WIDTH-1:0] rowData,
	output logic [`SCORE_BITS-1:0] score,
	output logic lockPulse
);

	boardIf bus ();

	// piece FSM and score
	gameCtrl ctrlInst (
		.count(count),
		.rst(rst),
		.left(left),
		.right(right),
		.newShape(newShape),
		.ctl(bus.control),
		.score(score),
		.lockPulse(lockPulse)
	);

	// candidate cells and collision
	pieceProbe probeInst (
		.ctl(bus.probeCmd),
		.brd(bus.probe)
	);

	// playfield
	boardStore storeInst (
		.count(count),
		.rst(rst),
		.brd(bus.store),
		.rowSel(rowSel),
		.rowData(rowData)
	);

endmodule

`default_nettype wire

// ==== tetrisCore_assert.sv ====
`default_nettype none

`include "tetris_macros.svh"

module tetrisCore_assert (
	input logic count,
	input logic rst,
	input logic lockPulse,
	input logic [`SCORE_BITS-1:0] score
);

	int failCount = 0;

	// lock is reported for a single cycle
	property pulseOneCycle;
		@(posedge count) disable iff (rst)
			lockPulse |=> !lockPulse;
	endproperty

	// score only steps by one, and only together with a lock
	property scoreStep;
		@(posedge count) disable iff (rst)
			!$stable(score) |-> (lockPulse && score == `SCORE_BITS'($past(score) + 1));
	endproperty

	property lockCounts;
		@(posedge count) disable iff (rst)
			lockPulse |-> (score == `SCORE_BITS'($past(score) + 1));
	endproperty

	// clean state coming out of reset
	property resetState;
		@(posedge count)
			rst |=> (score == '0 && !lockPulse);
	endproperty

	pulseCheck: assert property (pulseOneCycle) else begin
		failCount++;
		$error("lockPulse stayed high for more than one cycle");
	end

	stepCheck: assert property (scoreStep) else begin
		failCount++;
		$error("score changed by something other than a single lock");
	end

	lockCheck: assert property (lockCounts) else begin
		failCount++;
		$error("lockPulse fired without score rising by one");
	end

	resetCheck: assert property (resetState) else begin
		failCount++;
		$error("score or lockPulse not cleared by reset");
	end

endmodule

bind tetrisCore tetrisCore_assert assertInst (
	.count(count),
	.rst(rst),
	.lockPulse(lockPulse),
	.score(score)
);

`default_nettype wire

// ==== tetrisCore_tb.sv ====
`default_nettype none

`include "tetris_macros.svh"

module tetrisCore_tb;

	logic count;
	logic rst;
	logic left;
	logic right;
	logic [1:0] newShape;
	logic [`ROW_BITS-1:0] rowSel;
	logic [`BOARD_WIDTH-1:0] rowData;
	logic [`SCORE_BITS-1:0] score;
	logic lockPulse;

	// expected board holding locked pieces only with row 0 at the top
	logic [`BOARD_WIDTH-1:0] model [`BOARD_HEIGHT];
	logic [`SCORE_BITS-1:0] expectScore;
	integer seed;
	int mismatchCount;
	int timeoutCount;
	int assertCount;

	tetrisCore dut0 (
		.count(count),
		.rst(rst),
		.left(left),
		.right(right),
		.newShape(newShape),
		.rowSel(rowSel),
		.rowData(rowData),
		.score(score),
		.lockPulse(lockPulse)
	);

	initial count = 1'b0;
	always #5 count = ~count;

	task automatic nextCycle();
		@(posedge count);
		#1;
	endtask

	task automatic idleGap();
		int gap;
		gap = $random(seed) & 7;
		repeat (gap) nextCycle();
	endtask

	task automatic setCell(input int r, input int c);
		model[r][c] = 1'b1;
	endtask

	// cell layouts of the four spawn shapes anchored at their top left cell
	task automatic addPiece(input logic [1:0] shape, input int row, input int col);
		case (shape)
			`SHAPE_SQUARE: begin
				setCell(row, col);
				setCell(row, col + 1);
				setCell(row + 1, col);
				setCell(row + 1, col + 1);
			end
			`SHAPE_HBAR: begin
				for (int k = 0; k < 4; k++) begin
					setCell(row, col + k);
				end
			end
			`SHAPE_VBAR: begin
				for (int k = 0; k < 4; k++) begin
					setCell(row + k, col);
				end
			end
			default: begin
				setCell(row, col);
				setCell(row, col + 1);
				setCell(row, col + 2);
				setCell(row + 1, col + 1);
			end
		endcase
		expectScore = expectScore + `SCORE_BITS'(1);
	endtask

	// full rows vanish and everything above drops one row
	task automatic sweepModel();
		int r;
		r = `BOARD_HEIGHT - 1;
		while (r >= 0) begin
			if (&model[r]) begin
				for (int k = r; k > 0; k--) begin
					model[k] = model[k - 1];
				end
				model[0] = '0;
			end else begin
				r--;
			end
		end
	endtask

	task automatic checkRow(input int r, input logic [`BOARD_WIDTH-1:0] expected);
		if (rowData !== expected) begin
			mismatchCount++;
			$display("MISMATCH at time %0t: row %0d reads %b, expected %b",
				$time, r, rowData, expected);
		end
	endtask

	task automatic checkScore();
		if (score !== expectScore) begin
			mismatchCount++;
			$display("MISMATCH at time %0t: score is %0d, expected %0d",
				$time, score, expectScore);
		end
	endtask

	// expects rowSel at 0 and allows a fresh piece in rows 0 and 1
	task automatic checkWholeBoard(input logic [`BOARD_WIDTH-1:0] spawnMask);
		checkRow(0, model[0] | spawnMask);
		for (int r = 1; r < `BOARD_HEIGHT; r++) begin
			rowSel = `ROW_BITS'(r);
			#1;
			if (r == 1) begin
				checkRow(r, model[r] | spawnMask);
			end else begin
				checkRow(r, model[r]);
			end
		end
		rowSel = '0;
	endtask

	// starts right after lockPulse rises with row 19 selected
	// row 0 is left out since a sweep may shift the board two cycles after the lock
	task automatic checkLockedBoard();
		checkRow(`BOARD_HEIGHT - 1, model[`BOARD_HEIGHT - 1]);
		for (int r = `BOARD_HEIGHT - 2; r >= 1; r--) begin
			rowSel = `ROW_BITS'(r);
			#1;
			checkRow(r, model[r]);
		end
		rowSel = '0;
	endtask

	task automatic waitLock(input string what);
		int n;
		n = 0;
		rowSel = `ROW_BITS'(`BOARD_HEIGHT - 1);
		nextCycle();
		while (!lockPulse && n < 400) begin
			nextCycle();
			n++;
		end
		if (!lockPulse) begin
			timeoutCount++;
			$display("Timeout: the %s never locked", what);
		end
	endtask

	// a new piece shows up in row 0 one cycle after its spawn
	task automatic waitSpawn(input string what);
		int n;
		n = 0;
		rowSel = '0;
		nextCycle();
		while (rowData == '0 && n < 200) begin
			nextCycle();
			n++;
		end
		if (rowData == '0) begin
			timeoutCount++;
			$display("Timeout: the %s never spawned", what);
		end
	endtask

	// square steered by a key held for a number of column steps
	task automatic dropSteered(input logic goLeft, input int steps, input int col);
		newShape = `SHAPE_SQUARE;
		if (goLeft) begin
			left = 1'b0;
		end else begin
			right = 1'b0;
		end
		waitSpawn("steered square");
		repeat (4 * steps) nextCycle();
		left = 1'b1;
		right = 1'b1;
		waitLock("steered square");
		addPiece(`SHAPE_SQUARE, `BOARD_HEIGHT - 2, col);
		checkLockedBoard();
		checkScore();
		// idle while the controller runs the row sweep
		idleGap();
	endtask

	initial begin
		seed = 32'h4e5c81cc;
		mismatchCount = 0;
		timeoutCount = 0;
		expectScore = '0;
		for (int r = 0; r < `BOARD_HEIGHT; r++) begin
			model[r] = '0;
		end
		rst = 1'b1;
		left = 1'b1;
		right = 1'b1;
		newShape = `SHAPE_SQUARE;
		rowSel = '0;

		// empty board and zero score while reset is still held
		nextCycle();
		checkScore();
		checkWholeBoard('0);
		#1;
		rst = 1'b0;

		// five squares fill the two bottom rows
		dropSteered(1'b1, 5, 0);
		dropSteered(1'b0, 3, 8);
		dropSteered(1'b1, 3, 2);
		dropSteered(1'b0, 1, 6);
		dropSteered(1'b1, 1, 4);
		sweepModel();

		// after the sweep only the next square is on the board
		waitSpawn("square after the sweep");
		checkScore();
		checkWholeBoard(`BOARD_WIDTH'(10'h060));

		// that square drops with no key held
		waitLock("plain square");
		addPiece(`SHAPE_SQUARE, `BOARD_HEIGHT - 2, `SPAWN_COL);
		checkLockedBoard();
		checkScore();

		// tee stem lands on top of the square
		idleGap();
		newShape = `SHAPE_TEE;
		waitLock("tee");
		addPiece(`SHAPE_TEE, `BOARD_HEIGHT - 4, `SPAWN_COL);
		checkLockedBoard();
		checkScore();

		// bars pushed against the side walls
		idleGap();
		newShape = `SHAPE_HBAR;
		left = 1'b0;
		waitLock("horizontal bar");
		left = 1'b1;
		addPiece(`SHAPE_HBAR, `BOARD_HEIGHT - 1, 0);
		checkLockedBoard();
		checkScore();

		idleGap();
		newShape = `SHAPE_VBAR;
		right = 1'b0;
		waitLock("vertical bar");
		right = 1'b1;
		addPiece(`SHAPE_VBAR, `BOARD_HEIGHT - 4, `BOARD_WIDTH - 1);
		checkLockedBoard();
		checkScore();

		assertCount = dut0.assertInst.failCount;
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatchCount, timeoutCount, assertCount);
		if (mismatchCount == 0 && timeoutCount == 0 && assertCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tetrisCore.f ====
+incdir+.
tetrisPkg.sv
boardIf.sv
pieceProbe.sv
boardStore.sv
gameCtrl.sv
tetrisCore.sv
tetrisCore_assert.sv
tetrisCore_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tetrisCore_tb -f tetrisCore.f

run: compile
	./obj_dir/VtetrisCore_tb | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
